// File: uartPkg.sv
package uartPkg;

    // ------------------------------
    // data and configuration widths
    // ------------------------------
    localparam int dataWidth  = 8;   // one data byte
    localparam int baudWidth  = 16;  // clocks per bit field
    localparam int frameWidth = 4;   // bits per frame field

    // legal frame lengths, anything else is treated as 8 data bits
    localparam int minFrameBits = 5;
    localparam int maxFrameBits = 8;

    // ------------------------------
    // reset values of the config registers
    // ------------------------------
    localparam int defaultClocksPerBit = 10416;  // 100 MHz / 9600 baud
    localparam int defaultFrameBits    = 8;

    // ------------------------------
    // receive FIFO sizing
    // ------------------------------
    localparam int rxFifoDepth    = 16;  // power of two, pointers wrap on their own
    localparam int fifoCountWidth = 5;   // holds 0 to rxFifoDepth

endpackage

// File: syncFifo.sv
`timescale 1ns/1ps

module syncFifo import uartPkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      writeEn,    // push dataIn unless full
    input  logic                      readReq,    // pop head unless empty
    input  logic [dataWidth-1:0]      dataIn,
    output logic [dataWidth-1:0]      dataOut,    // head entry, show-ahead
    output logic [fifoCountWidth-1:0] wordCount,
    output logic                      empty,
    output logic                      full
);

    logic [dataWidth-1:0]             mem [rxFifoDepth];
    logic [$clog2(rxFifoDepth)-1:0]   writePtr;
    logic [$clog2(rxFifoDepth)-1:0]   readPtr;
    logic                             doWrite;
    logic                             doRead;

    // qualified strobes, full drops writes and empty drops pops
    assign doWrite = writeEn && !full;
    assign doRead  = readReq && !empty;

    assign empty   = (wordCount == '0);
    assign full    = (wordCount == fifoCountWidth'(rxFifoDepth));
    assign dataOut = mem[readPtr];  // oldest entry always on the output

    // storage
    always_ff @(posedge clk) begin
        if (doWrite)
            mem[writePtr] <= dataIn;
    end

    // pointers and count
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            writePtr  <= '0;
            readPtr   <= '0;
            wordCount <= '0;
        end else begin
            if (doWrite)
                writePtr <= writePtr + 1'b1;  // wraps at depth
            if (doRead)
                readPtr <= readPtr + 1'b1;
            case ({doWrite, doRead})
                2'b10:   wordCount <= wordCount + 1'b1;
                2'b01:   wordCount <= wordCount - 1'b1;
                default: wordCount <= wordCount;  // idle, or push and pop together
            endcase
        end
    end

endmodule

// File: uartTransmitter.sv
`timescale 1ns/1ps

module uartTransmitter import uartPkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  txDataValid,     // core holds a byte to send
    input  logic [dataWidth-1:0]  txDataIn,
    input  logic [baudWidth-1:0]  clocksPerCycle,
    input  logic [frameWidth-1:0] bitsPerFrame,
    output logic                  txAccept,        // byte taken in this cycle
    output logic                  tx
);

    typedef enum logic [1:0] {
        stIdle,
        stStart,
        stData,
        stStop
    } stateType;

    stateType              state;
    logic [baudWidth-1:0]  baudCount;  // clocks into the current bit
    logic [baudWidth-1:0]  lastCount;  // final clock of a bit period
    logic                  bitDone;
    logic [frameWidth-1:0] bitCount;   // data bits already sent
    logic [frameWidth-1:0] frameBits;  // frame length of the frame in flight
    logic [frameWidth-1:0] cleanBits;
    logic [dataWidth-1:0]  shiftReg;

    // out of range lengths fall back to a full byte
    assign cleanBits = (bitsPerFrame < minFrameBits || bitsPerFrame > maxFrameBits)
                     ? frameWidth'(maxFrameBits) : bitsPerFrame;

    assign lastCount = (clocksPerCycle == '0) ? '0 : clocksPerCycle - 1'b1;
    assign bitDone   = (baudCount >= lastCount);
    assign txAccept  = (state == stIdle) && txDataValid;

    // ------------------------------
    // frame sequencer
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= stIdle;
            baudCount <= '0;
            bitCount  <= '0;
            frameBits <= frameWidth'(maxFrameBits);
            tx        <= 1'b1;  // line idles high
        end else begin
            case (state)
                stIdle: begin
                    baudCount <= '0;
                    bitCount  <= '0;
                    if (txAccept) begin
                        frameBits <= cleanBits;  // config change waits for next frame
                        tx        <= 1'b0;       // start bit
                        state     <= stStart;
                    end
                end
                stStart: begin
                    baudCount <= bitDone ? '0 : baudCount + 1'b1;
                    if (bitDone) begin
                        tx    <= shiftReg[0];  // lsb first
                        state <= stData;
                    end
                end
                stData: begin
                    baudCount <= bitDone ? '0 : baudCount + 1'b1;
                    if (bitDone && bitCount == frameBits - 1'b1) begin
                        tx    <= 1'b1;  // stop bit
                        state <= stStop;
                    end else if (bitDone) begin
                        tx       <= shiftReg[0];
                        bitCount <= bitCount + 1'b1;
                    end
                end
                default: begin  // stStop
                    baudCount <= bitDone ? '0 : baudCount + 1'b1;
                    if (bitDone)
                        state <= stIdle;  // can accept on the next cycle
                end
            endcase
        end
    end

    // data shifter, next bit always sits in bit 0
    always_ff @(posedge clk) begin
        if (txAccept)
            shiftReg <= txDataIn;
        else if (bitDone && (state == stStart || state == stData))
            shiftReg <= shiftReg >> 1;
    end

endmodule

// File: uartReceiver.sv
`timescale 1ns/1ps

module uartReceiver import uartPkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [baudWidth-1:0]  clocksPerCycle,
    input  logic [frameWidth-1:0] bitsPerFrame,
    input  logic                  rx,        // asynchronous serial line
    output logic                  rxStrobe,  // one cycle, rxByte is new
    output logic [dataWidth-1:0]  rxByte
);

    typedef enum logic [1:0] {
        stIdle,
        stStart,
        stData,
        stStop
    } stateType;

    stateType              state;
    logic                  rxMeta;     // first synchronizer stage
    logic                  rxSync;     // second stage, safe to use
    logic                  rxLast;     // rxSync one cycle ago
    logic [baudWidth-1:0]  baudCount;
    logic [baudWidth-1:0]  lastCount;  // full bit period
    logic [baudWidth-1:0]  halfCount;
    logic [baudWidth-1:0]  lastHalf;   // half bit period
    logic                  bitDone;
    logic [frameWidth-1:0] bitCount;
    logic [frameWidth-1:0] frameBits;
    logic [frameWidth-1:0] cleanBits;
    logic [dataWidth-1:0]  shiftReg;   // fills from the msb side

    assign cleanBits = (bitsPerFrame < minFrameBits || bitsPerFrame > maxFrameBits)
                     ? frameWidth'(maxFrameBits) : bitsPerFrame;

    assign lastCount = (clocksPerCycle == '0) ? '0 : clocksPerCycle - 1'b1;
    assign halfCount = clocksPerCycle >> 1;
    assign lastHalf  = (halfCount == '0) ? '0 : halfCount - 1'b1;
    assign bitDone   = (baudCount >= lastCount);

    // ------------------------------
    // synchronizer and edge history
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rxMeta <= 1'b1;
            rxSync <= 1'b1;
            rxLast <= 1'b1;
        end else begin
            rxMeta <= rx;
            rxSync <= rxMeta;
            rxLast <= rxSync;
        end
    end

    // ------------------------------
    // frame sampler
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= stIdle;
            baudCount <= '0;
            bitCount  <= '0;
            frameBits <= frameWidth'(maxFrameBits);
            rxStrobe  <= 1'b0;
        end else begin
            rxStrobe <= 1'b0;
            case (state)
                stIdle: begin
                    baudCount <= '0;
                    bitCount  <= '0;
                    if (rxLast && !rxSync) begin  // falling edge, maybe a start bit
                        frameBits <= cleanBits;
                        state     <= stStart;
                    end
                end
                stStart: begin
                    baudCount <= (baudCount >= lastHalf) ? '0 : baudCount + 1'b1;
                    if (baudCount >= lastHalf)
                        state <= rxSync ? stIdle : stData;  // glitch goes back to idle
                end
                stData: begin
                    baudCount <= bitDone ? '0 : baudCount + 1'b1;
                    if (bitDone && bitCount == frameBits - 1'b1)
                        state <= stStop;
                    else if (bitDone)
                        bitCount <= bitCount + 1'b1;
                end
                default: begin  // stStop, sampled mid bit
                    baudCount <= bitDone ? '0 : baudCount + 1'b1;
                    if (bitDone) begin
                        rxStrobe <= rxSync;  // low stop bit means no strobe
                        state    <= stIdle;
                    end
                end
            endcase
        end
    end

    // data path, lsb arrives first
    always_ff @(posedge clk) begin
        if (state == stData && bitDone)
            shiftReg <= {rxSync, shiftReg[dataWidth-1:1]};
        if (state == stStop && bitDone)
            rxByte <= shiftReg >> (dataWidth - frameBits);  // right-justify, upper bits 0
    end

endmodule

// File: uartCore.sv
`timescale 1ns/1ps

module uartCore import uartPkg::*; (
    input  logic                  clk,
    input  logic                  reset,

    // master write data
    input  logic [dataWidth-1:0]  txDataIn,
    input  logic [baudWidth-1:0]  clocksPerCycleIn,
    input  logic [frameWidth-1:0] bitsPerFrameIn,
    input  logic                  rxIreIn,
    input  logic                  txIreIn,

    // master strobes, one cycle each
    input  logic                  txDataLoadEn,
    input  logic                  configLoadEn,
    input  logic                  rxDataReadReq,

    // visible state
    output logic [dataWidth-1:0]  txData,
    output logic [dataWidth-1:0]  rxData,          // FIFO head
    output logic                  rxValid,
    output logic                  txReady,
    output logic [baudWidth-1:0]  clocksPerCycle,
    output logic [frameWidth-1:0] bitsPerFrame,
    output logic                  rxIre,
    output logic                  txIre,

    output logic                  txIrq,
    output logic                  rxIrq,

    output logic                  tx,
    input  logic                  rx
);

    logic                 txDataValid;     // hidden, byte waiting for the transmitter
    logic                 txAccept;        // transmitter took txData
    logic                 rxStrobe;        // receiver has a good byte
    logic [dataWidth-1:0] rxByte;
    logic                 rxEmpty;
    logic                 rxFull;
    logic                 txIrePrev;       // edge detect history
    logic                 txDataValidPrev;

    assign rxValid = !rxEmpty;

    // ------------------------------
    // interrupts
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            txIrq           <= 1'b0;
            rxIrq           <= 1'b0;
            txIrePrev       <= 1'b0;
            txDataValidPrev <= 1'b0;
        end else begin
            // enable rising with nothing queued, or queued byte just taken
            txIrq <= (!txDataValid && !txIrePrev && txIre)
                   || (txIre && txDataValidPrev && !txDataValid);
            rxIrq <= rxIre && rxStrobe && !rxFull;  // one pulse per byte stored
            txIrePrev       <= txIre;
            txDataValidPrev <= txDataValid;
        end
    end

    // ------------------------------
    // master visible registers
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            txData         <= '0;
            clocksPerCycle <= baudWidth'(defaultClocksPerBit);
            bitsPerFrame   <= frameWidth'(defaultFrameBits);
            rxIre          <= 1'b0;
            txIre          <= 1'b0;
        end else begin
            if (txDataLoadEn)
                txData <= txDataIn;  // last write wins while busy
            if (configLoadEn) begin
                clocksPerCycle <= clocksPerCycleIn;
                bitsPerFrame   <= bitsPerFrameIn;
                rxIre          <= rxIreIn;
                txIre          <= txIreIn;
            end
        end
    end

    // transmit handshake state, a load beats a same-cycle accept
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            txReady     <= 1'b1;
            txDataValid <= 1'b0;
        end else if (txDataLoadEn) begin
            txReady     <= 1'b0;
            txDataValid <= 1'b1;
        end else if (txAccept) begin
            txReady     <= 1'b1;
            txDataValid <= 1'b0;
        end
    end

    // ------------------------------
    // datapath blocks
    // ------------------------------
    uartTransmitter u_transmitter (
        .clk,
        .reset,
        .txDataValid,
        .txDataIn       (txData),
        .clocksPerCycle,
        .bitsPerFrame,
        .txAccept,
        .tx
    );

    uartReceiver u_receiver (
        .clk,
        .reset,
        .clocksPerCycle,
        .bitsPerFrame,
        .rx,
        .rxStrobe,
        .rxByte
    );

    // count is internal only, status comes from empty and full
    syncFifo u_rxFifo (
        .clk,
        .reset,
        .writeEn   (rxStrobe),
        .readReq   (rxDataReadReq),
        .dataIn    (rxByte),
        .dataOut   (rxData),
        .wordCount (),
        .empty     (rxEmpty),
        .full      (rxFull)
    );

endmodule

// File: uartCore_checker.sv
`timescale 1ns/1ps

module uartCoreChecker (
    input logic       clk,
    input logic       reset,
    input logic       txIrq,
    input logic       rxIrq,
    input logic       rxIre,
    input logic       txReady,
    input logic       tx,
    input logic       rxValid,
    input logic [1:0] txState   // transmitter FSM state
);

    localparam logic [1:0] txIdleState = 2'b00;  // first enum entry of the transmitter

    // ------------------------------
    // interrupt pulses
    // ------------------------------
    txIrqPulse: assert property (@(posedge clk) disable iff (reset) txIrq |=> !txIrq)
        else $error("txIrq stayed high for two cycles");
    rxIrqPulse: assert property (@(posedge clk) disable iff (reset) rxIrq |=> !rxIrq)
        else $error("rxIrq stayed high for two cycles");
    rxIrqEnabled: assert property (@(posedge clk) disable iff (reset) rxIrq |-> $past(rxIre))
        else $error("rxIrq fired with rxIre clear");

    // line idles high between frames
    txIdleHigh: assert property (@(posedge clk) disable iff (reset)
        (txReady && txState == txIdleState) |-> tx)
        else $error("tx low while the transmitter is idle");

    resetRelease: assert property (@(posedge clk) $fell(reset) |-> !$rose(rxValid))
        else $error("rxValid rose on reset release");

endmodule

bind uartCore uartCoreChecker u_checker (
    .clk     (clk),
    .reset   (reset),
    .txIrq   (txIrq),
    .rxIrq   (rxIrq),
    .rxIre   (rxIre),
    .txReady (txReady),
    .tx      (tx),
    .rxValid (rxValid),
    .txState (u_transmitter.state)
);

// File: tb_uartCore.sv
`timescale 1ns/1ps

module tb_uartCore import uartPkg::*; ();

    localparam int          testBaud  = 8;         // clocks per bit in every test
    localparam int          waitLimit = 5000;      // cycles before any wait gives up
    localparam logic [15:0] lfsrSeed  = 16'd22465;

    logic                  clk;
    logic                  reset;
    logic [dataWidth-1:0]  txDataIn;
    logic [baudWidth-1:0]  clocksPerCycleIn;
    logic [frameWidth-1:0] bitsPerFrameIn;
    logic                  rxIreIn;
    logic                  txIreIn;
    logic                  txDataLoadEn;
    logic                  configLoadEn;
    logic                  rxDataReadReq;
    logic [dataWidth-1:0]  txData;
    logic [dataWidth-1:0]  rxData;
    logic                  rxValid;
    logic                  txReady;
    logic [baudWidth-1:0]  clocksPerCycle;
    logic [frameWidth-1:0] bitsPerFrame;
    logic                  rxIre;
    logic                  txIre;
    logic                  txIrq;
    logic                  rxIrq;
    logic                  serialLine;  // tx looped straight back into rx

    logic [15:0]           lfsr;
    logic [dataWidth-1:0]  expectQ [$];  // bytes still owed by the receiver
    int                    txIrqCount;
    int                    rxIrqCount;

    uartCore u_dut (
        .clk, .reset, .txDataIn, .clocksPerCycleIn, .bitsPerFrameIn, .rxIreIn, .txIreIn,
        .txDataLoadEn, .configLoadEn, .rxDataReadReq, .txData, .rxData, .rxValid, .txReady,
        .clocksPerCycle, .bitsPerFrame, .rxIre, .txIre, .txIrq, .rxIrq,
        .tx (serialLine),
        .rx (serialLine)
    );

    always #2 clk = ~clk;  // 4 ns period

    // interrupt pulses are counted at the falling edge where they are stable
    always @(negedge clk) begin
        if (txIrq)
            txIrqCount = txIrqCount + 1;
        if (rxIrq)
            rxIrqCount = rxIrqCount + 1;
    end

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic stepCycle();
        @(posedge clk);
        #0.5;  // drive and sample point sits clear of the edge
    endtask

    task automatic abortRun();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic checkByte(input string name, input logic [dataWidth-1:0] actual,
                             input logic [dataWidth-1:0] expected);
        if (actual !== expected) begin
            $display("Error: %s expected 0x%h got 0x%h", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkFlag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("Error: %s expected 0x%h got 0x%h", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkBaud(input string name, input logic [baudWidth-1:0] actual,
                             input logic [baudWidth-1:0] expected);
        if (actual !== expected) begin
            $display("Error: %s expected 0x%h got 0x%h", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkFrame(input string name, input logic [frameWidth-1:0] actual,
                              input logic [frameWidth-1:0] expected);
        if (actual !== expected) begin
            $display("Error: %s expected 0x%h got 0x%h", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkCount(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("Error: %s expected 0x%h got 0x%h", name, expected, actual);
            abortRun();
        end
    endtask

    // galois form with taps 16 14 13 11
    function automatic logic [15:0] stepLfsr(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic nextRandomByte(output logic [dataWidth-1:0] value);
        value = '0;
        for (int i = 0; i < dataWidth; i++) begin
            lfsr  = stepLfsr(lfsr);                      // one step per bit
            value = {value[dataWidth-2:0], lfsr[0]};
        end
    endtask

    task automatic waitTxReady();
        int cycles = 0;
        while (!txReady) begin
            stepCycle();
            cycles++;
            if (cycles > waitLimit) begin
                $display("Timeout: txReady did not return after a load");
                abortRun();
            end
        end
    endtask

    // line must stay high longer than any run inside a frame
    task automatic waitLineIdle();
        int cycles = 0;
        int idleRun = 0;
        while (idleRun < (maxFrameBits + 4) * testBaud) begin
            stepCycle();
            cycles++;
            idleRun = (serialLine && txReady) ? idleRun + 1 : 0;
            if (cycles > waitLimit) begin
                $display("Timeout: serial line never went idle");
                abortRun();
            end
        end
    endtask

    task automatic waitTxIrqs(input int count);
        int cycles = 0;
        while (txIrqCount < count) begin
            stepCycle();
            cycles++;
            if (cycles > waitLimit) begin
                $display("Timeout: expected transmit interrupt pulses did not arrive");
                abortRun();
            end
        end
    endtask

    task automatic configure(input logic [frameWidth-1:0] bits, input logic rxIreValue,
                             input logic txIreValue);
        clocksPerCycleIn = baudWidth'(testBaud);
        bitsPerFrameIn   = bits;
        rxIreIn          = rxIreValue;
        txIreIn          = txIreValue;
        configLoadEn     = 1'b1;
        stepCycle();
        configLoadEn     = 1'b0;
        checkBaud("clocksPerCycle", clocksPerCycle, baudWidth'(testBaud));
        checkFrame("bitsPerFrame", bitsPerFrame, bits);
        checkFlag("rxIre", rxIre, rxIreValue);
        checkFlag("txIre", txIre, txIreValue);
    endtask

    task automatic sendByte(input logic [dataWidth-1:0] value);
        waitTxReady();
        txDataIn     = value;
        txDataLoadEn = 1'b1;
        stepCycle();
        txDataLoadEn = 1'b0;
        checkByte("txData", txData, value);
        checkFlag("txReady", txReady, 1'b0);  // held until the transmitter takes it
    endtask

    // upper bits beyond the frame length come back as zero
    task automatic sendRandom(input int count, input int bits);
        logic [dataWidth-1:0] value;
        logic [dataWidth-1:0] mask;
        mask = dataWidth'((1 << bits) - 1);
        for (int i = 0; i < count; i++) begin
            nextRandomByte(value);
            sendByte(value);
            expectQ.push_back(value & mask);
        end
    endtask

    task automatic popByte(input logic [dataWidth-1:0] expected);
        checkFlag("rxValid", rxValid, 1'b1);
        checkByte("rxData", rxData, expected);
        rxDataReadReq = 1'b1;
        stepCycle();
        rxDataReadReq = 1'b0;
    endtask

    task automatic readBack(input int count);
        for (int i = 0; i < count; i++)
            popByte(expectQ.pop_front());
        expectQ.delete();                    // dropped overflow bytes
        checkFlag("rxValid", rxValid, 1'b0);
    endtask

    // ------------------------------
    // tests
    // ------------------------------
    task automatic testResetState();
        checkFlag("txReady", txReady, 1'b1);
        checkFlag("rxValid", rxValid, 1'b0);
        checkFlag("txIrq", txIrq, 1'b0);
        checkFlag("rxIrq", rxIrq, 1'b0);
        checkFlag("tx", serialLine, 1'b1);
        checkBaud("clocksPerCycle", clocksPerCycle, baudWidth'(defaultClocksPerBit));
        checkFrame("bitsPerFrame", bitsPerFrame, frameWidth'(defaultFrameBits));
        checkFlag("rxIre", rxIre, 1'b0);
        checkFlag("txIre", txIre, 1'b0);
    endtask

    task automatic testConfigLoad();
        configure(4'd6, 1'b1, 1'b1);  // readback checked inside
        configure(4'd8, 1'b0, 1'b0);
        sendByte(8'hA5);
        expectQ.push_back(8'hA5);
        waitLineIdle();
        readBack(1);
    endtask

    task automatic testLoopback(input int bits);
        configure(frameWidth'(bits), 1'b0, 1'b0);
        sendRandom(5, bits);
        waitLineIdle();
        readBack(5);
    endtask

    task automatic testInterrupts();
        configure(4'd8, 1'b0, 1'b0);
        txIrqCount = 0;
        rxIrqCount = 0;
        configure(4'd8, 1'b0, 1'b1);  // enable while nothing is queued
        waitTxIrqs(1);
        sendRandom(3, 8);             // one more pulse per accept
        waitTxIrqs(4);
        waitLineIdle();
        checkCount("txIrq pulses", txIrqCount, 4);
        checkCount("rxIrq pulses", rxIrqCount, 0);
        readBack(3);
        configure(4'd8, 1'b1, 1'b0);
        txIrqCount = 0;
        rxIrqCount = 0;
        sendRandom(3, 8);
        waitLineIdle();
        checkCount("rxIrq pulses", rxIrqCount, 3);
        checkCount("txIrq pulses", txIrqCount, 0);
        readBack(3);
        configure(4'd8, 1'b0, 1'b0);
    endtask

    task automatic testOverflow();
        configure(4'd8, 1'b1, 1'b0);     // only stored bytes raise rxIrq
        rxIrqCount = 0;
        sendRandom(rxFifoDepth + 2, 8);  // last two find the FIFO full
        waitLineIdle();
        checkCount("rxIrq pulses", rxIrqCount, rxFifoDepth);
        readBack(rxFifoDepth);
    endtask

    initial begin
        clk              = 1'b0;
        reset            = 1'b1;
        txDataIn         = '0;
        clocksPerCycleIn = '0;
        bitsPerFrameIn   = '0;
        rxIreIn          = 1'b0;
        txIreIn          = 1'b0;
        txDataLoadEn     = 1'b0;
        configLoadEn     = 1'b0;
        rxDataReadReq    = 1'b0;
        lfsr             = lfsrSeed;
        txIrqCount       = 0;
        rxIrqCount       = 0;
        repeat (10) @(posedge clk);
        #0.5;
        reset = 1'b0;
        stepCycle();
        testResetState();
        testConfigLoad();
        testLoopback(8);
        testLoopback(5);
        testInterrupts();
        testOverflow();
        $display("all tests passed");
        $finish;
    end

endmodule

// File: sources.f
uartPkg.sv
syncFifo.sv
uartTransmitter.sv
uartReceiver.sv
uartCore.sv
uartCore_checker.sv
tb_uartCore.sv
